/* rtl/rf_cfg_pkg.sv */
// ============================
// Register file geometry and base types. Imported by every block that
// sizes storage, addresses or client ports.
// ============================
package rf_cfg_pkg;

  localparam int DATA_W       = 32;              // One word per register.
  localparam int ADDR_W       = 5;
  localparam int NUM_REGS     = 32;
  localparam int NUM_RD_PORTS = 2;               // Two operand fetch ports.
  localparam int NUM_CLIENTS  = 2;               // Execute unit and load unit.

  // Partial write widths used by the merge logic.
  localparam int HALF_W = DATA_W / 2;
  localparam int BYTE_W = 8;

  // Width of a client index, kept at one bit or more.
  localparam int CLIENT_W = (NUM_CLIENTS > 1) ? $clog2(NUM_CLIENTS) : 1;

  typedef logic [DATA_W-1:0] reg_word_t;
  typedef logic [ADDR_W-1:0] reg_addr_t;

endpackage

/* rtl/rf_bus_pkg.sv */
// ============================
// Writeback channel between the clients and the register file.
// Holds the size encoding and the request payload.
// ============================
package rf_bus_pkg;

  import rf_cfg_pkg::*;

  typedef enum logic [1:0] {
    WR_WORD = 2'd0,                              // Whole register is replaced.
    WR_HALF = 2'd1,                              // Low half only.
    WR_BYTE = 2'd2                               // Low byte only.
  } wr_size_e;

  // Payload that a client keeps stable for as long as its req is high.
  typedef struct packed {
    reg_addr_t addr;
    reg_word_t data;
    wr_size_e  size;
  } wr_req_t;

endpackage

/* rtl/reg_file.sv */
// ============================
// Integer register file with one merging write port, combinational
// read ports and a per-register write lock table.
// ============================
`timescale 1ns/1ns

module reg_file
  import rf_cfg_pkg::*;
  import rf_bus_pkg::*;
(
  input  logic      gated_i_clk,
  input  logic      i_rst_n,
  input  logic      i_wr_en,
  input  wr_req_t   i_wr,
  input  logic      i_lock_we,
  input  reg_addr_t i_lock_addr,
  input  logic      i_lock_val,
  input  reg_addr_t i_rs_addr [NUM_RD_PORTS],
  output reg_word_t o_rs_data [NUM_RD_PORTS]
);

  reg_word_t           regs_q [NUM_REGS];
  logic [NUM_REGS-1:0] lock_q;
  reg_word_t           old_word;
  reg_word_t           merged;
  logic                wr_ok;

  // Builds the new register value from the old one and the request.
  function automatic reg_word_t merge_word(
    input reg_word_t old_w,
    input reg_word_t new_w,
    input wr_size_e  size
  );
    reg_word_t res;
    case (size)
      WR_HALF: res = {old_w[DATA_W-1:HALF_W], new_w[HALF_W-1:0]};
      WR_BYTE: res = {old_w[DATA_W-1:BYTE_W], new_w[BYTE_W-1:0]};
      default: res = new_w;                      // Unused code acts as a full word.
    endcase
    return res;
  endfunction

  assign old_word = regs_q[i_wr.addr];
  assign merged   = merge_word(old_word, i_wr.data, i_wr.size);

  // A locked register or register 0 drops the write without notice.
  assign wr_ok = i_wr_en && (i_wr.addr != '0) && !lock_q[i_wr.addr];

  always_ff @(posedge gated_i_clk) begin
    if (!i_rst_n) begin
      for (int r = 0; r < NUM_REGS; r++) begin
        regs_q[r] <= '0;
      end
    end else if (wr_ok) begin
      regs_q[i_wr.addr] <= merged;               // Index 0 never gets here, so it stays zero.
    end
  end

  always_ff @(posedge gated_i_clk) begin
    if (!i_rst_n) begin
      lock_q <= '0;
    end else if (i_lock_we) begin
      lock_q[i_lock_addr] <= i_lock_val;         // Seen by writes from the next edge on.
    end
  end

  for (genvar p = 0; p < NUM_RD_PORTS; p++) begin : g_rd_port
    assign o_rs_data[p] = regs_q[i_rs_addr[p]];
  end

endmodule

/* rtl/wr_arbiter.sv */
// ============================
// Round-robin arbiter for the single write port. Each client uses a
// four-phase req/ack handshake and gets one write pulse per handshake.
// ============================
`timescale 1ns/1ns

module wr_arbiter
  import rf_cfg_pkg::*;
  import rf_bus_pkg::*;
(
  input  logic                   gated_i_clk,
  input  logic                   i_rst_n,
  input  logic [NUM_CLIENTS-1:0] i_req,
  input  wr_req_t                i_wr [NUM_CLIENTS],
  output logic [NUM_CLIENTS-1:0] o_ack,
  output logic                   o_wr_en,
  output wr_req_t                o_wr
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_COMMIT,
    ST_RELEASE
  } arb_state_e;

  arb_state_e             state_q;
  logic [CLIENT_W-1:0]    grant_q;
  logic [CLIENT_W-1:0]    last_q;
  logic [NUM_CLIENTS-1:0] ack_q;
  logic [CLIENT_W-1:0]    pick;
  logic                   any_req;
  logic                   contended;

  // Search starts one past the last contention winner and wraps around.
  always_comb begin
    int cand;
    pick    = last_q;
    any_req = 1'b0;
    for (int k = 1; k <= NUM_CLIENTS; k++) begin
      cand = (int'(last_q) + k) % NUM_CLIENTS;
      if (!any_req && i_req[cand]) begin
        pick    = CLIENT_W'(cand);
        any_req = 1'b1;
      end
    end
  end

  assign contended = ($countones(i_req) > 1);

  always_ff @(posedge gated_i_clk) begin
    if (!i_rst_n) begin
      state_q <= ST_IDLE;
      grant_q <= '0;
      last_q  <= CLIENT_W'(NUM_CLIENTS - 1);     // Client 0 is next after reset.
      ack_q   <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (any_req) begin
            grant_q <= pick;
            state_q <= ST_COMMIT;
            if (contended) begin
              last_q <= pick;                    // Only contested grants move the pointer.
            end
          end
        end
        ST_COMMIT: begin
          ack_q[grant_q] <= 1'b1;                // Write lands on this same edge.
          state_q        <= ST_RELEASE;
        end
        ST_RELEASE: begin
          if (!i_req[grant_q]) begin
            ack_q   <= '0;
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // COMMIT lasts exactly one cycle, which makes the enable a single pulse.
  assign o_wr_en = (state_q == ST_COMMIT);
  assign o_wr    = i_wr[grant_q];                // Stable because the granted req is held.
  assign o_ack   = ack_q;

endmodule

/* rtl/rf_subsys.sv */
// ============================
// Register file subsystem top. Two writeback clients share the write
// port through the arbiter; two read ports serve operand fetch.
// ============================
`timescale 1ns/1ns

module rf_subsys
  import rf_cfg_pkg::*;
  import rf_bus_pkg::*;
(
  input  logic                   gated_i_clk,
  input  logic                   i_rst_n,
  input  logic [NUM_CLIENTS-1:0] i_req,
  input  wr_req_t                i_wr [NUM_CLIENTS],
  output logic [NUM_CLIENTS-1:0] o_ack,
  input  logic                   i_lock_we,
  input  reg_addr_t              i_lock_addr,
  input  logic                   i_lock_val,
  input  reg_addr_t              i_rs_addr [NUM_RD_PORTS],
  output reg_word_t              o_rs_data [NUM_RD_PORTS]
);

  logic    arb_wr_en;
  wr_req_t arb_wr;

  wr_arbiter u_arb (
    .gated_i_clk (gated_i_clk),
    .i_rst_n     (i_rst_n),
    .i_req       (i_req),
    .i_wr        (i_wr),
    .o_ack       (o_ack),
    .o_wr_en     (arb_wr_en),
    .o_wr        (arb_wr)
  );

  // The lock port bypasses the arbiter and goes straight to storage.
  reg_file u_rf (
    .gated_i_clk (gated_i_clk),
    .i_rst_n     (i_rst_n),
    .i_wr_en     (arb_wr_en),
    .i_wr        (arb_wr),
    .i_lock_we   (i_lock_we),
    .i_lock_addr (i_lock_addr),
    .i_lock_val  (i_lock_val),
    .i_rs_addr   (i_rs_addr),
    .o_rs_data   (o_rs_data)
  );

endmodule

/* tb/rf_asserts.sv */
// ============================
// Handshake and read port assertions for the register file subsystem.
// Bound into the top level by the bind statement below.
// ============================
`timescale 1ns/1ns

module rf_asserts
  import rf_cfg_pkg::*;
(
  input logic                   gated_i_clk,
  input logic                   i_rst_n,
  input logic [NUM_CLIENTS-1:0] i_req,
  input logic [NUM_CLIENTS-1:0] i_ack,
  input logic                   i_wr_en,
  input reg_addr_t              i_rs_addr [NUM_RD_PORTS],
  input reg_word_t              i_rs_data [NUM_RD_PORTS]
);

  for (genvar c = 0; c < NUM_CLIENTS; c++) begin : g_client
    ack_rise_needs_req: assert property (@(posedge gated_i_clk) disable iff (!i_rst_n)
      $rose(i_ack[c]) |-> $past(i_req[c]))
      else $error("Ack of client %0d rose while its req was low", c);

    ack_fall_after_req: assert property (@(posedge gated_i_clk) disable iff (!i_rst_n)
      $fell(i_ack[c]) |-> !$past(i_req[c]))
      else $error("Ack of client %0d fell while its req was still high", c);
  end

  ack_onehot: assert property (@(posedge gated_i_clk) disable iff (!i_rst_n)
    $onehot0(i_ack))
    else $error("More than one ack is high");

  // The commit pulse lasts one cycle and is followed by exactly one ack rising.
  wr_pulse_then_ack: assert property (@(posedge gated_i_clk) disable iff (!i_rst_n)
    i_wr_en |=> (!i_wr_en && $rose(|i_ack)))
    else $error("Write pulse was not a single cycle followed by an ack");

  ack_after_pulse: assert property (@(posedge gated_i_clk) disable iff (!i_rst_n)
    $rose(|i_ack) |-> $past(i_wr_en))
    else $error("Ack rose without a write pulse in the cycle before");

  for (genvar p = 0; p < NUM_RD_PORTS; p++) begin : g_rd
    reg0_reads_zero: assert property (@(posedge gated_i_clk) disable iff (!i_rst_n)
      (i_rs_addr[p] == '0) |-> (i_rs_data[p] == '0))
      else $error("Read port %0d returned a nonzero value for register 0", p);
  end

endmodule

bind rf_subsys rf_asserts u_asserts (
  .gated_i_clk (gated_i_clk),
  .i_rst_n     (i_rst_n),
  .i_req       (i_req),
  .i_ack       (o_ack),
  .i_wr_en     (arb_wr_en),
  .i_rs_addr   (i_rs_addr),
  .i_rs_data   (o_rs_data)
);

/* tb/rf_tb.sv */
// ============================
// Directed testbench for the register file subsystem. Checks reads
// against a reference model after each handshake.
// ============================
`timescale 1ns/1ns

module rf_tb
  import rf_cfg_pkg::*;
  import rf_bus_pkg::*;
();

  localparam int WAIT_LIMIT = 40;                // Cycles allowed for any one wait.

  logic                   gated_i_clk;
  logic                   i_rst_n;
  logic [NUM_CLIENTS-1:0] req;
  wr_req_t                wr [NUM_CLIENTS];
  logic [NUM_CLIENTS-1:0] ack;
  logic                   lock_we;
  reg_addr_t              lock_addr;
  logic                   lock_val;
  reg_addr_t              rs_addr [NUM_RD_PORTS];
  reg_word_t              rs_data [NUM_RD_PORTS];

  reg_word_t model_regs [NUM_REGS];
  logic      model_lock [NUM_REGS];
  string     cur_name;
  int        test_errs;
  int        err_count;
  int        tests_run;
  int        tests_failed;
  int        rr_next;                            // Client expected to win the next contention.

  rf_subsys UUT (
    .gated_i_clk (gated_i_clk),
    .i_rst_n     (i_rst_n),
    .i_req       (req),
    .i_wr        (wr),
    .o_ack       (ack),
    .i_lock_we   (lock_we),
    .i_lock_addr (lock_addr),
    .i_lock_val  (lock_val),
    .i_rs_addr   (rs_addr),
    .o_rs_data   (rs_data)
  );

  initial begin
    gated_i_clk = 1'b0;
    forever #4 gated_i_clk = ~gated_i_clk;
  end

  // Bits of the register that a write of the given size replaces.
  function automatic reg_word_t write_mask(input wr_size_e size);
    case (size)
      WR_HALF: return 32'h0000_ffff;
      WR_BYTE: return 32'h0000_00ff;
      default: return 32'hffff_ffff;
    endcase
  endfunction

  task automatic model_write(input reg_addr_t addr, input reg_word_t data, input wr_size_e size);
    reg_word_t mask;
    mask = write_mask(size);
    if (addr != 0 && !model_lock[addr]) begin
      model_regs[addr] = (model_regs[addr] & ~mask) | (data & mask);
    end
  endtask

  task automatic abort_run(input string why);
    $display("Timeout: %s", why);
    $display("Something failed");
    $finish;
  endtask

  task automatic compare_word(input reg_word_t exp, input reg_word_t act);
    assert (act === exp) else begin
      $display("Error %s: expected %08h, actual %08h", cur_name, exp, act);
      test_errs++;
    end
  endtask

  task automatic compare_client(input int exp, input int act);
    assert (act == exp) else begin
      $display("Error %s: expected client %0d first, actual client %0d", cur_name, exp, act);
      test_errs++;
    end
  endtask

  task automatic read_and_compare(input reg_addr_t a0, input reg_addr_t a1);
    @(posedge gated_i_clk);
    #1;
    rs_addr[0] = a0;
    rs_addr[1] = a1;
    #2;
    compare_word(model_regs[a0], rs_data[0]);
    compare_word(model_regs[a1], rs_data[1]);
  endtask

  // Full four-phase handshake for one client, then the model takes the write.
  task automatic client_write(input int c, input reg_addr_t addr, input reg_word_t data,
                              input wr_size_e size);
    int waited;
    @(posedge gated_i_clk);
    #1;
    wr[c]  = '{addr: addr, data: data, size: size};
    req[c] = 1'b1;
    waited = 0;
    while (ack[c] !== 1'b1 && waited < WAIT_LIMIT) begin
      @(posedge gated_i_clk);
      #1;
      waited++;
    end
    if (ack[c] !== 1'b1) abort_run($sformatf("client %0d never saw its ack rise", c));
    req[c] = 1'b0;
    waited = 0;
    while (ack[c] !== 1'b0 && waited < WAIT_LIMIT) begin
      @(posedge gated_i_clk);
      #1;
      waited++;
    end
    if (ack[c] !== 1'b0) abort_run($sformatf("client %0d never saw its ack fall", c));
    model_write(addr, data, size);
  endtask

  // Both clients raise req on the same edge; reports which one was acked first.
  task automatic dual_write(input wr_req_t w0, input wr_req_t w1, output int first);
    int         waited;
    logic [1:0] seen;
    @(posedge gated_i_clk);
    #1;
    wr[0]  = w0;
    wr[1]  = w1;
    req    = 2'b11;
    seen   = 2'b00;
    first  = -1;
    waited = 0;
    while ((seen != 2'b11 || ack !== 2'b00) && waited < WAIT_LIMIT) begin
      @(posedge gated_i_clk);
      #1;
      waited++;
      for (int c = 0; c < NUM_CLIENTS; c++) begin
        if (ack[c] === 1'b1 && req[c]) begin
          req[c]  = 1'b0;
          seen[c] = 1'b1;
          if (first < 0) first = c;
        end
      end
    end
    if (seen != 2'b11 || ack !== 2'b00) abort_run("simultaneous handshakes did not complete");
  endtask

  task automatic set_lock(input reg_addr_t addr, input logic val);
    @(posedge gated_i_clk);
    #1;
    lock_we   = 1'b1;
    lock_addr = addr;
    lock_val  = val;
    @(posedge gated_i_clk);
    #1;
    lock_we = 1'b0;
    model_lock[addr] = val;
  endtask

  task automatic start_test(input string name);
    cur_name  = name;
    test_errs = 0;
  endtask

  task automatic report_test();
    tests_run++;
    err_count += test_errs;
    if (test_errs != 0) tests_failed++;
    $display("Test %s finished with %0d errors", cur_name, test_errs);
  endtask

  task automatic after_reset_reads();
    start_test("reset_state");
    assert (ack === '0) else begin
      $display("Error %s: expected ack %b, actual ack %b", cur_name, 2'b00, ack);
      test_errs++;
    end
    for (int r = 0; r < NUM_REGS; r++) begin
      read_and_compare(reg_addr_t'(r), reg_addr_t'(NUM_REGS - 1 - r));
    end
    report_test();
  endtask

  task automatic full_word_writes();
    reg_addr_t addr;
    start_test("full_words");
    for (int i = 0; i < 12; i++) begin
      addr = (i == 5) ? reg_addr_t'(0) : reg_addr_t'($urandom % NUM_REGS);
      client_write(i % NUM_CLIENTS, addr, $urandom, WR_WORD);
      read_and_compare(addr, reg_addr_t'($urandom % NUM_REGS));
    end
    report_test();
  endtask

  task automatic partial_writes();
    reg_addr_t addr;
    start_test("partial_writes");
    for (int i = 0; i < 6; i++) begin
      addr = reg_addr_t'(1 + $urandom % (NUM_REGS - 1));
      client_write(i % NUM_CLIENTS, addr, $urandom, WR_WORD);
      client_write((i + 1) % NUM_CLIENTS, addr, $urandom, WR_HALF);
      read_and_compare(addr, addr);
      client_write(i % NUM_CLIENTS, addr, $urandom, WR_BYTE);
      read_and_compare(addr, 0);
    end
    report_test();
  endtask

  task automatic simultaneous_requests();
    reg_addr_t addr;
    wr_req_t   w [NUM_CLIENTS];
    int        first;
    start_test("contention");
    addr = reg_addr_t'(1 + $urandom % (NUM_REGS - 1));
    for (int pair = 0; pair < 2; pair++) begin
      w[0] = '{addr: addr, data: $urandom, size: WR_WORD};
      w[1] = '{addr: addr, data: $urandom, size: WR_WORD};
      dual_write(w[0], w[1], first);
      compare_client(rr_next, first);
      model_write(addr, w[rr_next].data, WR_WORD);          // Winner writes first.
      model_write(addr, w[1 - rr_next].data, WR_WORD);
      rr_next = 1 - rr_next;
      read_and_compare(addr, addr);
    end
    report_test();
  endtask

  task automatic locked_writes();
    reg_addr_t addr;
    reg_word_t blocked;
    start_test("locks");
    for (int c = 0; c < NUM_CLIENTS; c++) begin
      addr    = reg_addr_t'(1 + $urandom % (NUM_REGS - 1));
      blocked = $urandom;
      client_write(c, addr, $urandom, WR_WORD);
      set_lock(addr, 1'b1);
      client_write(c, addr, blocked, WR_WORD);              // Acked but dropped.
      read_and_compare(addr, addr);
      set_lock(addr, 1'b0);
      client_write(c, addr, blocked, WR_WORD);
      read_and_compare(addr, 0);
    end
    report_test();
  endtask

  initial begin
    i_rst_n   = 1'b0;
    req       = '0;
    wr[0]     = '0;
    wr[1]     = '0;
    lock_we   = 1'b0;
    lock_addr = '0;
    lock_val  = 1'b0;
    rs_addr[0] = '0;
    rs_addr[1] = '0;
    err_count    = 0;
    tests_run    = 0;
    tests_failed = 0;
    rr_next      = 0;                            // Client 0 wins the first contention.
    for (int r = 0; r < NUM_REGS; r++) begin
      model_regs[r] = '0;
      model_lock[r] = 1'b0;
    end
    void'($urandom(32'hdc16));
    repeat (8) @(posedge gated_i_clk);
    #1;
    i_rst_n = 1'b1;

    after_reset_reads();
    full_word_writes();
    partial_writes();
    simultaneous_requests();
    locked_writes();

    $display("Tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed,
             err_count);
    if (err_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* compile.f */
rtl/rf_cfg_pkg.sv
rtl/rf_bus_pkg.sv
rtl/reg_file.sv
rtl/wr_arbiter.sv
rtl/rf_subsys.sv
tb/rf_asserts.sv
tb/rf_tb.sv

/* Bender.yml */
package:
  name: rf_subsys

sources:
  # Packages first, the RTL after them.
  - rtl/rf_cfg_pkg.sv
  - rtl/rf_bus_pkg.sv
  - rtl/reg_file.sv
  - rtl/wr_arbiter.sv
  - rtl/rf_subsys.sv

  # Testbench and bound assertions.
  - target: test
    files:
      - tb/rf_asserts.sv
      - tb/rf_tb.sv
